// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module vrf_tb -f files.f -o vrf_sim
	@out="$$(./obj_dir/vrf_sim)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: files.f
src/vrf_pkg.sv
src/sdp_bwe_ram.sv
src/vrf_write_bank.sv
src/vrf_read_merge.sv
src/vrf_top.sv
tb/vrf_tb.sv

// File: src/sdp_bwe_ram.sv
`timescale 1ns/100ps

module sdp_bwe_ram
(
   input  logic           clk,
   // write port
   input  vrf_pkg::be_t   we_be_i,
   input  vrf_pkg::addr_t waddr_i,
   input  vrf_pkg::data_t wdata_i,
   // read port
   input  vrf_pkg::addr_t raddr_i,
   output vrf_pkg::data_t rdata_o
);

   import vrf_pkg::*;

   localparam int DEPTH  = 2 ** ADDR_W;
   localparam int LANE_W = WORD_W / NB_BYTES;

   data_t mem [DEPTH];

   // one write per lane, each lane has its own enable
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < NB_BYTES; b++)
      begin
         if (we_be_i[b])
         begin
            mem[waddr_i][b*LANE_W +: LANE_W] <= wdata_i[b*LANE_W +: LANE_W];
         end
      end
   end

   // registered read
   // a write to the same address on the same edge is not seen yet
   always_ff @(posedge clk)
   begin
      rdata_o <= mem[raddr_i];
   end

endmodule

// File: src/vrf_pkg.sv
package vrf_pkg;

   // word geometry
   localparam int WORD_W   = 32;
   localparam int NB_BYTES = 4;

   // 64 registers
   localparam int ADDR_W = 6;

   typedef logic [WORD_W-1:0]   data_t;
   typedef logic [NB_BYTES-1:0] be_t;
   typedef logic [ADDR_W-1:0]   addr_t;

   // write request, a nonzero be marks a write
   typedef struct packed {
      addr_t addr;
      be_t   be;
      data_t data;
   } wr_req_t;

   // read request
   typedef struct packed {
      logic  en;
      addr_t addr;
   } rd_req_t;

   // read response, valid two edges after the request
   typedef struct packed {
      logic  valid;
      data_t data;
   } rd_rsp_t;

endpackage

// File: src/vrf_read_merge.sv
`timescale 1ns/100ps

module vrf_read_merge
#(
   parameter int W_PORTS = 3
)
(
   input  logic             clk,
   input  logic             rstn,
   input  vrf_pkg::rd_req_t rd_i,
   // raw word of this read port from every bank
   input  vrf_pkg::data_t   bank_data_i [W_PORTS],
   output vrf_pkg::rd_rsp_t rd_o
);

   import vrf_pkg::*;

   logic  en_q;
   data_t merged;

   // xor over all banks decodes the stored value
   always_comb
   begin
      merged = '0;
      for (int p = 0; p < W_PORTS; p++)
      begin
         merged = merged ^ bank_data_i[p];
      end
   end

   // en_q lines up with the RAM output register
   // then one more edge for the response register
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         en_q       <= 1'b0;
         rd_o.valid <= 1'b0;
      end
      else
      begin
         en_q       <= rd_i.en;
         rd_o.valid <= en_q;
         // data only moves on a real read
         if (en_q)
         begin
            rd_o.data <= merged;
         end
      end
   end

endmodule

// File: src/vrf_top.sv
`timescale 1ns/100ps

module vrf_top
#(
   parameter int W_PORTS = 3,
   parameter int R_PORTS = 2
)
(
   input  logic             clk,
   input  logic             rstn,
   input  vrf_pkg::wr_req_t wr_i [W_PORTS],
   input  vrf_pkg::rd_req_t rd_i [R_PORTS],
   output vrf_pkg::rd_rsp_t rd_o [R_PORTS]
);

   import vrf_pkg::*;

   addr_t rd_addr   [R_PORTS];
   addr_t peer_addr [W_PORTS][W_PORTS-1];
   data_t peer_out  [W_PORTS][W_PORTS-1];
   data_t peer_in   [W_PORTS][W_PORTS-1];
   data_t bank_rd   [W_PORTS][R_PORTS];
   data_t merge_in  [R_PORTS][W_PORTS];

   // read addresses go to every bank
   for (genvar r = 0; r < R_PORTS; r++)
   begin : g_rd_addr
      assign rd_addr[r] = rd_i[r].addr;
   end

   for (genvar p = 0; p < W_PORTS; p++)
   begin : g_bank
      // slot k of bank p serves port PEER
      // and bank p sits in slot SLOT of that peer's list
      for (genvar k = 0; k < W_PORTS - 1; k++)
      begin : g_cross
         localparam int PEER = (k < p) ? k : k + 1;
         localparam int SLOT = (p < PEER) ? p : p - 1;

         assign peer_addr[p][k] = wr_i[PEER].addr;
         assign peer_in[p][k]   = peer_out[PEER][SLOT];
      end

      vrf_write_bank
      #(
         .W_PORTS (W_PORTS),
         .R_PORTS (R_PORTS)
      )
      u_bank
      (
         .clk         (clk),
         .rstn        (rstn),
         .wr_i        (wr_i[p]),
         .peer_addr_i (peer_addr[p]),
         .peer_data_o (peer_out[p]),
         .peer_data_i (peer_in[p]),
         .raddr_i     (rd_addr),
         .rdata_o     (bank_rd[p])
      );
   end

   // transpose bank outputs, one group per read port
   for (genvar r = 0; r < R_PORTS; r++)
   begin : g_merge
      for (genvar p = 0; p < W_PORTS; p++)
      begin : g_col
         assign merge_in[r][p] = bank_rd[p][r];
      end

      vrf_read_merge
      #(
         .W_PORTS (W_PORTS)
      )
      u_merge
      (
         .clk         (clk),
         .rstn        (rstn),
         .rd_i        (rd_i[r]),
         .bank_data_i (merge_in[r]),
         .rd_o        (rd_o[r])
      );
   end

endmodule

// File: src/vrf_write_bank.sv
`timescale 1ns/100ps

module vrf_write_bank
#(
   parameter int W_PORTS = 3,
   parameter int R_PORTS = 2
)
(
   input  logic               clk,
   input  logic               rstn,
   // this bank's own write port
   input  vrf_pkg::wr_req_t   wr_i,
   // raw write addresses of the other ports, ascending, own index skipped
   input  vrf_pkg::addr_t     peer_addr_i [W_PORTS-1],
   // this bank's stored words at the peer addresses
   output vrf_pkg::data_t     peer_data_o [W_PORTS-1],
   // each peer's stored word at this port's address
   input  vrf_pkg::data_t     peer_data_i [W_PORTS-1],
   // read side, one copy per read port
   input  vrf_pkg::addr_t     raddr_i [R_PORTS],
   output vrf_pkg::data_t     rdata_o [R_PORTS]
);

   import vrf_pkg::*;

   wr_req_t wr_q;
   data_t   enc_word;

   // stage one, hold the request while the peer copies are read
   // only be needs a reset so that nothing is written after it
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_q.be <= '0;
      end
      else
      begin
         wr_q <= wr_i;
      end
   end

   // encoded word
   // stored ^ all other banks at this address gives back wr_q.data
   always_comb
   begin
      enc_word = wr_q.data;
      for (int k = 0; k < W_PORTS - 1; k++)
      begin
         enc_word = enc_word ^ peer_data_i[k];
      end
   end

   // peer copies
   // read at the address another port is writing this cycle
   for (genvar k = 0; k < W_PORTS - 1; k++)
   begin : g_peer_ram
      sdp_bwe_ram u_ram
      (
         .clk     (clk),
         .we_be_i (wr_q.be),
         .waddr_i (wr_q.addr),
         .wdata_i (enc_word),
         .raddr_i (peer_addr_i[k]),
         .rdata_o (peer_data_o[k])
      );
   end

   // read copies, same contents, one per read port
   for (genvar r = 0; r < R_PORTS; r++)
   begin : g_read_ram
      sdp_bwe_ram u_ram
      (
         .clk     (clk),
         .we_be_i (wr_q.be),
         .waddr_i (wr_q.addr),
         .wdata_i (enc_word),
         .raddr_i (raddr_i[r]),
         .rdata_o (rdata_o[r])
      );
   end

endmodule

// File: tb/vrf_stimulus.txt
# test | w0 addr be data | w1 addr be data | w2 addr be data | r0 en addr expect | r1 en addr expect
# test number in decimal, all other columns in hex, a line with end stops the run
# 1: idle after reset, no reads
1  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
1  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
1  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
# 2: one full-word write per port in turn, read back on both ports
2  01 f 3c9a17e5  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
2  00 0 00000000  02 f 8b04f2a6  00 0 00000000  0 00 00000000  0 00 00000000
2  00 0 00000000  00 0 00000000  03 f 51e6d039  1 01 3c9a17e5  1 01 3c9a17e5
2  00 0 00000000  00 0 00000000  00 0 00000000  1 02 8b04f2a6  1 02 8b04f2a6
2  00 0 00000000  00 0 00000000  00 0 00000000  1 03 51e6d039  1 03 51e6d039
# 3: all ports write in the same cycle
3  10 f a7d2c418  11 f 0f63b95c  12 f e48a2d71  0 00 00000000  0 00 00000000
3  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
3  00 0 00000000  00 0 00000000  00 0 00000000  1 10 a7d2c418  1 11 0f63b95c
3  00 0 00000000  00 0 00000000  00 0 00000000  1 12 e48a2d71  1 10 a7d2c418
# 4: partial writes merge with the old bytes
4  20 f 96b3e05d  21 f 2c7f8813  00 0 00000000  0 00 00000000  0 00 00000000
4  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
4  20 3 5e0147c9  00 0 00000000  21 6 d84a6b30  1 20 96b3e05d  1 21 2c7f8813
4  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
4  00 0 00000000  20 8 f1c02e9b  21 9 3a5d70e4  1 20 96b347c9  1 21 2c4a6b13
4  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
4  00 0 00000000  00 0 00000000  20 5 07e9c2b6  1 20 f1b347c9  1 21 3a4a6be4
4  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
4  00 0 00000000  00 0 00000000  00 0 00000000  1 20 f1e947b6  1 20 f1e947b6
# 5: overwrites by different ports, then back-to-back rewrites by one port
5  30 f 6d2b8e14  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
5  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
5  00 0 00000000  30 f c3f05a97  00 0 00000000  1 30 6d2b8e14  0 00 00000000
5  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
5  00 0 00000000  00 0 00000000  30 f 19a4d6e2  1 30 c3f05a97  0 00 00000000
5  31 f 4e87b3c0  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
5  31 f b5163f2d  00 0 00000000  00 0 00000000  1 30 19a4d6e2  0 00 00000000
5  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
5  00 0 00000000  00 0 00000000  00 0 00000000  1 31 b5163f2d  1 30 19a4d6e2
5  00 0 00000000  00 0 00000000  32 f 0a9c4e57  0 00 00000000  0 00 00000000
5  00 0 00000000  00 0 00000000  32 2 7731d8f6  0 00 00000000  0 00 00000000
5  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
5  00 0 00000000  00 0 00000000  00 0 00000000  1 32 0a9cd857  1 31 b5163f2d
# 6: both read ports busy every cycle while writes go elsewhere
6  38 f 8f1d2ac6  39 f 2e75c0b3  3a f d40b6e98  1 01 3c9a17e5  1 02 8b04f2a6
6  3b f 61c8f037  3c f 9a2e4d15  3d f c7509b4e  1 03 51e6d039  1 10 a7d2c418
6  3e f 05b6e7a1  3f f e3d92c68  04 f 7c41a5f2  1 11 0f63b95c  1 12 e48a2d71
6  00 0 00000000  00 0 00000000  00 0 00000000  1 38 8f1d2ac6  1 39 2e75c0b3
6  05 f 1b7ed093  00 0 00000000  00 0 00000000  1 3a d40b6e98  1 3b 61c8f037
6  00 0 00000000  06 f a8c3651f  00 0 00000000  1 3c 9a2e4d15  1 3d c7509b4e
6  00 0 00000000  00 0 00000000  07 f 4d92b87a  1 3e 05b6e7a1  1 3f e3d92c68
6  00 0 00000000  00 0 00000000  00 0 00000000  1 04 7c41a5f2  1 05 1b7ed093
6  00 0 00000000  00 0 00000000  00 0 00000000  1 06 a8c3651f  1 20 f1e947b6
6  00 0 00000000  00 0 00000000  00 0 00000000  1 07 4d92b87a  1 21 3a4a6be4
6  00 0 00000000  00 0 00000000  00 0 00000000  1 30 19a4d6e2  1 31 b5163f2d
6  00 0 00000000  00 0 00000000  00 0 00000000  0 00 00000000  0 00 00000000
end

// File: tb/vrf_tb.sv
`timescale 1ns/100ps

module vrf_tb;

   import vrf_pkg::*;

   localparam int W_PORTS = 3;
   localparam int R_PORTS = 2;
   // a read driven at one edge is seen on rd_o three edges later
   localparam int RD_DELAY = 3;

   // one line of the stimulus file
   typedef struct packed {
      int                    test;
      wr_req_t [W_PORTS-1:0] wr;
      rd_req_t [R_PORTS-1:0] rd;
      data_t   [R_PORTS-1:0] exp_data;
   } cmd_t;

   // response expected at a given edge
   typedef struct packed {
      int    due;
      int    test;
      int    port;
      logic  en;
      data_t data;
   } exp_t;

   logic    clk;
   logic    rstn;
   wr_req_t wr  [W_PORTS];
   rd_req_t rd  [R_PORTS];
   rd_rsp_t rsp [R_PORTS];

   cmd_t cmds  [$];
   exp_t exp_q [$];

   // seed of the random fill words
   int seed = 81840;

   int edge_n    = 0;
   int errors    = 0;
   int cur_test  = -1;
   int test_errs = 0;
   int n_passed  = 0;
   int n_failed  = 0;
   bit loaded    = 1'b0;

   vrf_top
   #(
      .W_PORTS (W_PORTS),
      .R_PORTS (R_PORTS)
   )
   dut_i
   (
      .clk  (clk),
      .rstn (rstn),
      .wr_i (wr),
      .rd_i (rd),
      .rd_o (rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic load_stimulus();
      int          fd;
      int          code;
      bit          done;
      string       tok;
      string       rest;
      logic [31:0] v [15];
      cmd_t        c;
      fd = $fopen("tb/vrf_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open tb/vrf_stimulus.txt");
         return;
      end
      done = 1'b0;
      while (!done)
      begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1 || tok == "end")
         begin
            done = 1'b1;
         end
         else if (tok[0] == "#")
         begin
            code = $fgets(rest, fd);
         end
         else
         begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                           v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
            if (code != 15)
            begin
               $display("stimulus line of test %s is incomplete", tok);
               errors++;
               done = 1'b1;
            end
            else
            begin
               c.test = tok.atoi();
               for (int p = 0; p < W_PORTS; p++)
               begin
                  c.wr[p].addr = v[3*p][ADDR_W-1:0];
                  c.wr[p].be   = v[3*p+1][NB_BYTES-1:0];
                  c.wr[p].data = v[3*p+2];
               end
               // read columns follow the write columns
               for (int r = 0; r < R_PORTS; r++)
               begin
                  c.rd[r].en     = v[3*W_PORTS+3*r][0];
                  c.rd[r].addr   = v[3*W_PORTS+3*r+1][ADDR_W-1:0];
                  c.exp_data[r]  = v[3*W_PORTS+3*r+2];
               end
               cmds.push_back(c);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic report_test();
      if (cur_test >= 0)
      begin
         if (test_errs == 0)
         begin
            $display("test %0d done, no errors", cur_test);
            n_passed++;
         end
         else
         begin
            $display("test %0d done, %0d errors", cur_test, test_errs);
            n_failed++;
         end
      end
   endtask

   task automatic drive_line(input cmd_t c);
      exp_t e;
      for (int p = 0; p < W_PORTS; p++)
      begin
         wr[p] <= c.wr[p];
      end
      for (int r = 0; r < R_PORTS; r++)
      begin
         rd[r]  <= c.rd[r];
         e.due  = edge_n + RD_DELAY;
         e.test = c.test;
         e.port = r;
         e.en   = c.rd[r].en;
         e.data = c.exp_data[r];
         exp_q.push_back(e);
      end
   endtask

   // compare every response that falls due at this edge
   task automatic check_due();
      exp_t e;
      while (exp_q.size() > 0 && exp_q[0].due == edge_n)
      begin
         e = exp_q.pop_front();
         if (e.test != cur_test)
         begin
            report_test();
            cur_test  = e.test;
            test_errs = 0;
         end
         if (e.en)
         begin
            assert (rsp[e.port].valid === 1'b1)
            else
            begin
               $display("read port %0d gave no response at %0d ns in test %0d",
                        e.port, $time, e.test);
               errors++;
               test_errs++;
            end
            if (rsp[e.port].valid === 1'b1)
            begin
               assert (rsp[e.port].data === e.data)
               else
               begin
                  $display("MISMATCH at %0d ns: test %0d read port %0d expected %08h got %08h",
                           $time, e.test, e.port, e.data, rsp[e.port].data);
                  errors++;
                  test_errs++;
               end
            end
         end
         else
         begin
            assert (rsp[e.port].valid === 1'b0)
            else
            begin
               $display("read port %0d gave a response without a request at %0d ns in test %0d",
                        e.port, $time, e.test);
               errors++;
               test_errs++;
            end
         end
      end
   endtask

   initial
   begin
      rstn <= 1'b0;
      for (int p = 0; p < W_PORTS; p++)
      begin
         wr[p] <= '0;
      end
      for (int r = 0; r < R_PORTS; r++)
      begin
         rd[r] <= '0;
      end
      load_stimulus();
      loaded = 1'b1;
      if (cmds.size() == 0)
      begin
         $display("no stimulus lines were read");
         $display("Test failures found");
         $finish;
      end
      else
      begin
         repeat (2) @(posedge clk);
         rstn <= 1'b1;
         foreach (cmds[i])
         begin
            @(posedge clk);
            edge_n++;
            check_due();
            drive_line(cmds[i]);
         end
         // let the last reads come back
         while (exp_q.size() > 0)
         begin
            @(posedge clk);
            edge_n++;
            check_due();
         end
         report_test();
         $display("%0d tests without errors, %0d tests with errors", n_passed, n_failed);
         if (errors == 0)
         begin
            $display("All tests passed!");
         end
         else
         begin
            $display("Test failures found");
         end
         $finish;
      end
   end

   // watchdog sized from the number of stimulus lines
   initial
   begin
      wait (loaded);
      #((cmds.size() + 20) * 100);
      $display("timeout, the run did not end after %0d cycles", cmds.size() + 20);
      $display("Test failures found");
      $finish;
   end

endmodule
